/* verilog/sched_config.svh */
// scheduler sizing
// register counts, issue widths and queue depths shared by all blocks

`ifndef SCHED_CONFIG_SVH
`define SCHED_CONFIG_SVH

// register files
`define SCHED_ARCH_REGS 32
`define SCHED_PHYS_REGS 64

// instructions renamed per cycle
`define SCHED_DECODE_WIDTH 2

// write-back ports, also used for commit frees
`define SCHED_WB_WIDTH 2

// issue queue entries
`define SCHED_ALU_DEPTH 8
`define SCHED_MEM_DEPTH 4

// pc carried with each instruction for the ROB and the units
`define SCHED_PC_WIDTH 32

`endif

/* verilog/sched_pkg.sv */
// scheduler types
// register indices, opcodes and the structs passed between rename and issue

`default_nettype none

`include "sched_config.svh"

package sched_pkg;

  typedef logic [$clog2(`SCHED_ARCH_REGS)-1:0] areg_t;
  typedef logic [$clog2(`SCHED_PHYS_REGS)-1:0] preg_t;
  typedef logic [$clog2(`SCHED_PHYS_REGS+1)-1:0] fl_cnt_t;
  typedef logic [`SCHED_PC_WIDTH-1:0] pc_t;

  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_LOAD,
    OP_STORE
  } sched_op_e;

  // one decoded lane from decode
  typedef struct packed {
    logic      valid;
    sched_op_e op;
    areg_t     src0;
    areg_t     src1;
    areg_t     dest;
    logic      dest_valid;
    pc_t       pc;
  } sched_req_t;

  typedef struct packed {
    logic  valid;
    areg_t adest;
    preg_t pdest;
    preg_t old_pdest;
    pc_t   pc;
  } rob_alloc_t;

  typedef struct packed {
    sched_op_e op;
    preg_t     psrc0;
    preg_t     psrc1;
    logic      src0_rdy;
    logic      src1_rdy;
    preg_t     pdest;
    logic      dest_valid;
    pc_t       pc;
  } iq_entry_t;

  typedef struct packed {
    logic      valid;
    sched_op_e op;
    preg_t     psrc0;
    preg_t     psrc1;
    preg_t     pdest;
    logic      dest_valid;
    pc_t       pc;
  } issue_t;

  typedef struct packed {
    logic  valid;
    preg_t preg;
  } wakeup_t;

  typedef struct packed {
    logic  valid;
    preg_t preg;
  } free_t;

  // loads and stores go to the in-order queue
  function automatic logic op_is_mem(input sched_op_e op);
    return (op == OP_LOAD) || (op == OP_STORE);
  endfunction

  // true when any write-back port broadcasts p this cycle
  function automatic logic wb_hit(input wakeup_t [`SCHED_WB_WIDTH-1:0] wb, input preg_t p);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < `SCHED_WB_WIDTH; i++) begin
      hit = hit | (wb[i].valid && (wb[i].preg == p));
    end
    return hit;
  endfunction

endpackage

`default_nettype wire

/* verilog/free_list.sv */
// physical register free list
// circular FIFO, up to two allocations and two frees per cycle

`timescale 1ns/1ps
`default_nettype none

`include "sched_config.svh"

module free_list import sched_pkg::*; (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic  [`SCHED_DECODE_WIDTH-1:0]   alloc_i,
  output preg_t [`SCHED_DECODE_WIDTH-1:0]   alloc_preg_o,
  output fl_cnt_t                           count_o,
  input  free_t [`SCHED_WB_WIDTH-1:0]       free_i
);

  localparam int PTR_W     = $clog2(`SCHED_PHYS_REGS);
  localparam int INIT_FREE = `SCHED_PHYS_REGS - `SCHED_ARCH_REGS;

  preg_t            slots_q [`SCHED_PHYS_REGS];
  logic [PTR_W-1:0] head_q, tail_q;
  logic [PTR_W-1:0] head_nxt, tail_nxt;
  logic [PTR_W-1:0] wr_ptr [`SCHED_WB_WIDTH];
  fl_cnt_t          cnt_q;
  fl_cnt_t          n_alloc, n_free;

  // lanes without a destination skip the head
  always_comb begin
    head_nxt = head_q;
    n_alloc  = '0;
    for (int i = 0; i < `SCHED_DECODE_WIDTH; i++) begin
      alloc_preg_o[i] = slots_q[head_nxt];
      if (alloc_i[i]) begin
        head_nxt = head_nxt + 1'b1;
        n_alloc  = n_alloc + 1'b1;
      end
    end
  end

  // freed registers appended in port order
  always_comb begin
    tail_nxt = tail_q;
    n_free   = '0;
    for (int i = 0; i < `SCHED_WB_WIDTH; i++) begin
      wr_ptr[i] = tail_nxt;
      if (free_i[i].valid) begin
        tail_nxt = tail_nxt + 1'b1;
        n_free   = n_free + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // pregs above the architectural range start out free
      for (int i = 0; i < `SCHED_PHYS_REGS; i++) begin
        slots_q[i] <= (i < INIT_FREE) ? preg_t'(i + `SCHED_ARCH_REGS) : '0;
      end
      head_q <= '0;
      tail_q <= PTR_W'(INIT_FREE);
      cnt_q  <= fl_cnt_t'(INIT_FREE);
    end else begin
      for (int i = 0; i < `SCHED_WB_WIDTH; i++) begin
        if (free_i[i].valid) begin
          slots_q[wr_ptr[i]] <= free_i[i].preg;
        end
      end
      head_q <= head_nxt;
      tail_q <= tail_nxt;
      cnt_q  <= cnt_q - n_alloc + n_free;
    end
  end

  assign count_o = cnt_q;

endmodule

`default_nettype wire

/* verilog/rename_table.sv */
// register alias table with physical busy bits
// renames both lanes, bypasses lane 0's destination into lane 1

`timescale 1ns/1ps
`default_nettype none

`include "sched_config.svh"

module rename_table import sched_pkg::*; (
  input  logic                              clk,
  input  logic                              rst_n,
  input  areg_t   [`SCHED_DECODE_WIDTH-1:0] src0_i,
  input  areg_t   [`SCHED_DECODE_WIDTH-1:0] src1_i,
  input  areg_t   [`SCHED_DECODE_WIDTH-1:0] dest_i,
  input  logic    [`SCHED_DECODE_WIDTH-1:0] dest_valid_i,
  input  preg_t   [`SCHED_DECODE_WIDTH-1:0] new_preg_i,
  input  logic                              commit_i,
  input  wakeup_t [`SCHED_WB_WIDTH-1:0]     wakeup_i,
  output preg_t   [`SCHED_DECODE_WIDTH-1:0] psrc0_o,
  output preg_t   [`SCHED_DECODE_WIDTH-1:0] psrc1_o,
  output preg_t   [`SCHED_DECODE_WIDTH-1:0] old_pdest_o,
  output logic    [`SCHED_DECODE_WIDTH-1:0] src0_rdy_o,
  output logic    [`SCHED_DECODE_WIDTH-1:0] src1_rdy_o
);

  preg_t                       map_q [`SCHED_ARCH_REGS];
  logic [`SCHED_PHYS_REGS-1:0] busy_q;

  always_comb begin
    for (int i = 0; i < `SCHED_DECODE_WIDTH; i++) begin
      psrc0_o[i]     = map_q[src0_i[i]];
      psrc1_o[i]     = map_q[src1_i[i]];
      old_pdest_o[i] = map_q[dest_i[i]];
      // a same-cycle wakeup counts as ready
      src0_rdy_o[i]  = !busy_q[psrc0_o[i]] || wb_hit(wakeup_i, psrc0_o[i]);
      src1_rdy_o[i]  = !busy_q[psrc1_o[i]] || wb_hit(wakeup_i, psrc1_o[i]);
      // older lanes in the group override the table, youngest writer wins
      for (int j = 0; j < i; j++) begin
        if (dest_valid_i[j] && (src0_i[i] == dest_i[j])) begin
          psrc0_o[i]    = new_preg_i[j];
          src0_rdy_o[i] = 1'b0;
        end
        if (dest_valid_i[j] && (src1_i[i] == dest_i[j])) begin
          psrc1_o[i]    = new_preg_i[j];
          src1_rdy_o[i] = 1'b0;
        end
        if (dest_valid_i[j] && (dest_i[i] == dest_i[j])) begin
          old_pdest_o[i] = new_preg_i[j];
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < `SCHED_ARCH_REGS; r++) begin
        map_q[r] <= preg_t'(r);
      end
      busy_q <= '0;
    end else begin
      for (int w = 0; w < `SCHED_WB_WIDTH; w++) begin
        if (wakeup_i[w].valid) begin
          busy_q[wakeup_i[w].preg] <= 1'b0;
        end
      end
      // lane order keeps the younger mapping
      if (commit_i) begin
        for (int i = 0; i < `SCHED_DECODE_WIDTH; i++) begin
          if (dest_valid_i[i]) begin
            map_q[dest_i[i]]      <= new_preg_i[i];
            busy_q[new_preg_i[i]] <= 1'b1;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/issue_queue.sv */
// age-ordered issue queue with wakeup snooping
// picks the oldest ready entry, or only the head when in order

`timescale 1ns/1ps
`default_nettype none

`include "sched_config.svh"

module issue_queue import sched_pkg::*; #(
  parameter int DEPTH    = 8,
  parameter bit IN_ORDER = 1'b0
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic      [`SCHED_DECODE_WIDTH-1:0] wr_i,
  input  iq_entry_t [`SCHED_DECODE_WIDTH-1:0] wr_entry_i,
  output logic      [$clog2(DEPTH+1)-1:0]     free_slots_o,
  input  wakeup_t   [`SCHED_WB_WIDTH-1:0]     wakeup_i,
  input  logic                                unit_ready_i,
  output issue_t                              issue_o
);

  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int IDX_W = $clog2(DEPTH);

  // entry 0 is the oldest
  iq_entry_t        ent_q   [DEPTH];
  iq_entry_t        ent_nxt [DEPTH];
  logic [CNT_W-1:0] cnt_q, cnt_nxt;
  logic             sel_valid;
  logic [IDX_W-1:0] sel_idx;

  // ================================================
  // select
  // ================================================
  always_comb begin
    sel_valid = 1'b0;
    sel_idx   = '0;
    if (unit_ready_i) begin
      for (int k = 0; k < DEPTH; k++) begin
        if (!sel_valid && (k < cnt_q) && (!IN_ORDER || (k == 0)) &&
            ent_q[k].src0_rdy && ent_q[k].src1_rdy) begin
          sel_valid = 1'b1;
          sel_idx   = IDX_W'(k);
        end
      end
    end
  end

  // ================================================
  // compact, append and snoop
  // ================================================
  always_comb begin
    ent_nxt = ent_q;
    cnt_nxt = cnt_q;
    // younger entries slide over the issued one
    if (sel_valid) begin
      for (int k = 0; k < DEPTH - 1; k++) begin
        if (k >= sel_idx) begin
          ent_nxt[k] = ent_q[k + 1];
        end
      end
      cnt_nxt = cnt_q - 1'b1;
    end
    for (int l = 0; l < `SCHED_DECODE_WIDTH; l++) begin
      if (wr_i[l]) begin
        for (int k = 0; k < DEPTH; k++) begin
          if (k == cnt_nxt) begin
            ent_nxt[k] = wr_entry_i[l];
          end
        end
        cnt_nxt = cnt_nxt + 1'b1;
      end
    end
    for (int k = 0; k < DEPTH; k++) begin
      if (wb_hit(wakeup_i, ent_nxt[k].psrc0)) begin
        ent_nxt[k].src0_rdy = 1'b1;
      end
      if (wb_hit(wakeup_i, ent_nxt[k].psrc1)) begin
        ent_nxt[k].src1_rdy = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    ent_q <= ent_nxt;
  end

  // registered command to the unit
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q   <= '0;
      issue_o <= '0;
    end else begin
      cnt_q              <= cnt_nxt;
      issue_o.valid      <= sel_valid;
      issue_o.op         <= ent_q[sel_idx].op;
      issue_o.psrc0      <= ent_q[sel_idx].psrc0;
      issue_o.psrc1      <= ent_q[sel_idx].psrc1;
      issue_o.pdest      <= ent_q[sel_idx].pdest;
      issue_o.dest_valid <= ent_q[sel_idx].dest_valid;
      issue_o.pc         <= ent_q[sel_idx].pc;
    end
  end

  assign free_slots_o = CNT_W'(DEPTH) - cnt_q;

endmodule

`default_nettype wire

/* verilog/scheduler.sv */
// two-wide rename and issue scheduler
// renames decoded pairs, allocates ROB entries and fills the ALU and memory queues

`timescale 1ns/1ps
`default_nettype none

`include "sched_config.svh"

module scheduler import sched_pkg::*; (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  sched_req_t [`SCHED_DECODE_WIDTH-1:0] sched_req_i,
  output logic                                 sched_ready_o,
  output rob_alloc_t [`SCHED_DECODE_WIDTH-1:0] rob_alloc_o,
  input  logic                                 rob_ready_i,
  input  free_t      [`SCHED_WB_WIDTH-1:0]     free_i,
  input  wakeup_t    [`SCHED_WB_WIDTH-1:0]     wakeup_i,
  output issue_t                               alu_issue_o,
  input  logic                                 alu_ready_i,
  output issue_t                               mem_issue_o,
  input  logic                                 mem_ready_i
);

  localparam int LANE_W = $clog2(`SCHED_DECODE_WIDTH + 1);

  logic                                     live_q;
  logic       [`SCHED_DECODE_WIDTH-1:0]     s0_accept, fl_alloc;
  preg_t      [`SCHED_DECODE_WIDTH-1:0]     fl_alloc_preg;
  fl_cnt_t                                  fl_count;
  logic       [`SCHED_DECODE_WIDTH-1:0]     s1_valid_q;
  sched_req_t [`SCHED_DECODE_WIDTH-1:0]     s1_req_q;
  preg_t      [`SCHED_DECODE_WIDTH-1:0]     s1_pdest_q;
  logic                                     s1_ready, s1_drain;
  areg_t      [`SCHED_DECODE_WIDTH-1:0]     s1_src0, s1_src1, s1_dest;
  logic       [`SCHED_DECODE_WIDTH-1:0]     rat_dest_valid, rat_src0_rdy, rat_src1_rdy;
  preg_t      [`SCHED_DECODE_WIDTH-1:0]     rat_psrc0, rat_psrc1, rat_old_pdest;
  logic       [LANE_W-1:0]                  alu_need, mem_need;
  logic       [$clog2(`SCHED_ALU_DEPTH+1)-1:0] alu_free_slots;
  logic       [$clog2(`SCHED_MEM_DEPTH+1)-1:0] mem_free_slots;
  logic       [`SCHED_DECODE_WIDTH-1:0]     alu_wr, mem_wr;
  iq_entry_t  [`SCHED_DECODE_WIDTH-1:0]     iq_entry;

  // ================================================
  // stage 0 accept and allocate
  // ================================================
  // ready stays low until the first edge after reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      live_q <= 1'b0;
    end else begin
      live_q <= 1'b1;
    end
  end

  assign sched_ready_o = live_q & s1_ready & (fl_count >= fl_cnt_t'(`SCHED_DECODE_WIDTH));

  always_comb begin
    for (int i = 0; i < `SCHED_DECODE_WIDTH; i++) begin
      s0_accept[i] = sched_req_i[i].valid & sched_ready_o;
      fl_alloc[i]  = s0_accept[i] & sched_req_i[i].dest_valid;
    end
  end

  free_list u_free_list (
    .clk          (clk),
    .rst_n        (rst_n),
    .alloc_i      (fl_alloc),
    .alloc_preg_o (fl_alloc_preg),
    .count_o      (fl_count),
    .free_i       (free_i)
  );

  // ================================================
  // stage 1 rename and drain
  // ================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid_q <= '0;
    end else if (s1_ready) begin
      s1_valid_q <= s0_accept;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_ready) begin
      s1_req_q   <= sched_req_i;
      s1_pdest_q <= fl_alloc_preg;
    end
  end

  // per-class lane counts against queue room
  always_comb begin
    alu_need = '0;
    mem_need = '0;
    for (int i = 0; i < `SCHED_DECODE_WIDTH; i++) begin
      s1_src0[i]        = s1_req_q[i].src0;
      s1_src1[i]        = s1_req_q[i].src1;
      s1_dest[i]        = s1_req_q[i].dest;
      rat_dest_valid[i] = s1_valid_q[i] & s1_req_q[i].dest_valid;
      if (s1_valid_q[i] && op_is_mem(s1_req_q[i].op)) begin
        mem_need = mem_need + 1'b1;
      end else if (s1_valid_q[i]) begin
        alu_need = alu_need + 1'b1;
      end
    end
  end

  assign s1_drain = (|s1_valid_q) & rob_ready_i &
                    (alu_need <= alu_free_slots) & (mem_need <= mem_free_slots);
  assign s1_ready = ~(|s1_valid_q) | s1_drain;

  rename_table u_rename_table (
    .clk          (clk),
    .rst_n        (rst_n),
    .src0_i       (s1_src0),
    .src1_i       (s1_src1),
    .dest_i       (s1_dest),
    .dest_valid_i (rat_dest_valid),
    .new_preg_i   (s1_pdest_q),
    .commit_i     (s1_drain),
    .wakeup_i     (wakeup_i),
    .psrc0_o      (rat_psrc0),
    .psrc1_o      (rat_psrc1),
    .old_pdest_o  (rat_old_pdest),
    .src0_rdy_o   (rat_src0_rdy),
    .src1_rdy_o   (rat_src1_rdy)
  );

  // lanes without a destination report zero pregs
  always_comb begin
    for (int i = 0; i < `SCHED_DECODE_WIDTH; i++) begin
      rob_alloc_o[i].valid     = s1_drain & s1_valid_q[i];
      rob_alloc_o[i].adest     = s1_req_q[i].dest;
      rob_alloc_o[i].pdest     = s1_req_q[i].dest_valid ? s1_pdest_q[i] : '0;
      rob_alloc_o[i].old_pdest = s1_req_q[i].dest_valid ? rat_old_pdest[i] : '0;
      rob_alloc_o[i].pc        = s1_req_q[i].pc;

      iq_entry[i].op         = s1_req_q[i].op;
      iq_entry[i].psrc0      = rat_psrc0[i];
      iq_entry[i].psrc1      = rat_psrc1[i];
      iq_entry[i].src0_rdy   = rat_src0_rdy[i];
      iq_entry[i].src1_rdy   = rat_src1_rdy[i];
      iq_entry[i].pdest      = s1_req_q[i].dest_valid ? s1_pdest_q[i] : '0;
      iq_entry[i].dest_valid = s1_req_q[i].dest_valid;
      iq_entry[i].pc         = s1_req_q[i].pc;

      alu_wr[i] = rob_alloc_o[i].valid & ~op_is_mem(s1_req_q[i].op);
      mem_wr[i] = rob_alloc_o[i].valid & op_is_mem(s1_req_q[i].op);
    end
  end

  // ================================================
  // issue queues
  // ================================================
  issue_queue #(
    .DEPTH    (`SCHED_ALU_DEPTH),
    .IN_ORDER (1'b0)
  ) u_alu_iq (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr_i         (alu_wr),
    .wr_entry_i   (iq_entry),
    .free_slots_o (alu_free_slots),
    .wakeup_i     (wakeup_i),
    .unit_ready_i (alu_ready_i),
    .issue_o      (alu_issue_o)
  );

  // loads and stores leave in program order
  issue_queue #(
    .DEPTH    (`SCHED_MEM_DEPTH),
    .IN_ORDER (1'b1)
  ) u_mem_iq (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr_i         (mem_wr),
    .wr_entry_i   (iq_entry),
    .free_slots_o (mem_free_slots),
    .wakeup_i     (wakeup_i),
    .unit_ready_i (mem_ready_i),
    .issue_o      (mem_issue_o)
  );

endmodule

`default_nettype wire

/* tests/scheduler_asserts.sv */
// scheduler property checks
// bound into the top level, covers reset, busy sources, free list and memory order

`timescale 1ns/1ps
`default_nettype none

`include "sched_config.svh"

module scheduler_asserts import sched_pkg::*; (
  input logic                                    clk,
  input logic                                    rst_n,
  input logic                                    sched_ready_i,
  input rob_alloc_t [`SCHED_DECODE_WIDTH-1:0]    rob_alloc_i,
  input issue_t                                  alu_issue_i,
  input issue_t                                  mem_issue_i,
  input logic [$clog2(`SCHED_PHYS_REGS)-1:0]     fl_head_i,
  input logic [$clog2(`SCHED_PHYS_REGS)-1:0]     fl_tail_i,
  input logic       [`SCHED_PHYS_REGS-1:0]       busy_i
);

  localparam int PTR_W = $clog2(`SCHED_PHYS_REGS);

  pc_t              last_mem_pc;
  logic [PTR_W-1:0] fl_occ;

  // pointer distance gives the free list occupancy
  assign fl_occ = fl_tail_i - fl_head_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_mem_pc <= '0;
    end else if (mem_issue_i.valid) begin
      last_mem_pc <= mem_issue_i.pc;
    end
  end

  quiet_in_reset: assert property (@(posedge clk) !rst_n |->
      !(alu_issue_i.valid || mem_issue_i.valid || rob_alloc_i[0].valid || rob_alloc_i[1].valid))
    else $error("valid issue or allocation during reset");

  alu_src_free: assert property (@(posedge clk) disable iff (!rst_n) alu_issue_i.valid |->
      !busy_i[alu_issue_i.psrc0] && !busy_i[alu_issue_i.psrc1])
    else $error("ALU command names a busy source");

  mem_src_free: assert property (@(posedge clk) disable iff (!rst_n) mem_issue_i.valid |->
      !busy_i[mem_issue_i.psrc0] && !busy_i[mem_issue_i.psrc1])
    else $error("memory command names a busy source");

  ready_needs_free: assert property (@(posedge clk) disable iff (!rst_n)
      (fl_occ < PTR_W'(`SCHED_DECODE_WIDTH)) |-> !sched_ready_i)
    else $error("decode ready while the free list is short");

  mem_in_order: assert property (@(posedge clk) disable iff (!rst_n)
      mem_issue_i.valid |-> (mem_issue_i.pc > last_mem_pc))
    else $error("memory commands out of program order");

endmodule

bind scheduler scheduler_asserts u_asserts (
  .clk           (clk),
  .rst_n         (rst_n),
  .sched_ready_i (sched_ready_o),
  .rob_alloc_i   (rob_alloc_o),
  .alu_issue_i   (alu_issue_o),
  .mem_issue_i   (mem_issue_o),
  .fl_head_i     (u_free_list.head_q),
  .fl_tail_i     (u_free_list.tail_q),
  .busy_i        (u_rename_table.busy_q)
);

`default_nettype wire

/* tests/scheduler_tb.sv */
// scheduler testbench
// LFSR stimulus, reference rename model and scoreboards for ROB and issue outputs

`timescale 1ns/1ps
`default_nettype none

`include "sched_config.svh"

module scheduler_tb import sched_pkg::*; ();

  localparam int   N_INSTR     = 400;
  localparam int   BP_START    = 150;
  localparam int   EXHAUST_AT  = 280;
  localparam int   CYCLE_LIMIT = 20 * N_INSTR + 200;
  localparam pc_t  PC_BASE     = 32'h1000;

  logic                                 clk;
  logic                                 rst_n;
  sched_req_t [`SCHED_DECODE_WIDTH-1:0] sched_req_i;
  logic                                 sched_ready_o;
  rob_alloc_t [`SCHED_DECODE_WIDTH-1:0] rob_alloc_o;
  logic                                 rob_ready_i;
  free_t      [`SCHED_WB_WIDTH-1:0]     free_i;
  wakeup_t    [`SCHED_WB_WIDTH-1:0]     wakeup_i;
  issue_t                               alu_issue_o;
  logic                                 alu_ready_i;
  issue_t                               mem_issue_o;
  logic                                 mem_ready_i;

  // reference model state
  preg_t      map_m    [`SCHED_ARCH_REGS];
  bit         busy_m   [`SCHED_PHYS_REGS];
  int         owner_id [`SCHED_PHYS_REGS];
  preg_t      fl_m     [$];
  bit         id_done  [N_INSTR];
  bit         id_dest  [N_INSTR];
  preg_t      id_old   [N_INSTR];
  rob_alloc_t exp_rob  [$];
  issue_t     exp_alu  [$];
  issue_t     exp_mem  [$];
  preg_t      pend_preg [$];
  int         pend_due  [$];
  free_t      [`SCHED_WB_WIDTH-1:0] free_nxt;

  bit [31:0] lfsr_q = 32'h622;
  int        cyc, gen_cnt, acc_cnt, issued_cnt, ret_id;
  int        alu_hold, mem_hold, hold_cnt;
  bit        req_taken, withhold, exhausted_seen, exhaust_done;

  scheduler DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .sched_req_i   (sched_req_i),
    .sched_ready_o (sched_ready_o),
    .rob_alloc_o   (rob_alloc_o),
    .rob_ready_i   (rob_ready_i),
    .free_i        (free_i),
    .wakeup_i      (wakeup_i),
    .alu_issue_o   (alu_issue_o),
    .alu_ready_i   (alu_ready_i),
    .mem_issue_o   (mem_issue_o),
    .mem_ready_i   (mem_ready_i)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ================================================
  // helpers
  // ================================================
  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_take(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  // renames one lane in program order, lane 1 sees lane 0's update
  function automatic void rename_lane(input sched_req_t r, input int id,
                                      output rob_alloc_t ra, output issue_t is);
    preg_t ps0, ps1, old, pd;
    ps0 = map_m[r.src0];
    ps1 = map_m[r.src1];
    old = map_m[r.dest];
    pd  = '0;
    if (r.dest_valid) begin
      pd           = fl_m.pop_front();
      map_m[r.dest] = pd;
      busy_m[pd]   = 1'b1;
      owner_id[pd] = id;
    end
    id_dest[id]   = r.dest_valid;
    id_old[id]    = old;
    ra.valid      = 1'b1;
    ra.adest      = r.dest;
    ra.pdest      = pd;
    ra.old_pdest  = r.dest_valid ? old : '0;
    ra.pc         = r.pc;
    is.valid      = 1'b1;
    is.op         = r.op;
    is.psrc0      = ps0;
    is.psrc1      = ps1;
    is.pdest      = pd;
    is.dest_valid = r.dest_valid;
    is.pc         = r.pc;
  endfunction

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_rob(input rob_alloc_t got, input rob_alloc_t exp, input int lane);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH rob_alloc_o[%0d] got %h expected %h", lane, got, exp));
    end
  endtask

  task automatic check_alu(input issue_t got, input issue_t exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH alu_issue_o got %h expected %h", got, exp));
    end
  endtask

  task automatic check_mem(input issue_t got, input issue_t exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH mem_issue_o got %h expected %h", got, exp));
    end
  endtask

  task automatic check_ready(input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH sched_ready_o got %h expected %h", got, exp));
    end
  endtask

  // ================================================
  // compare process, sampled mid-cycle
  // ================================================
  task automatic note_issue(input issue_t is);
    if (busy_m[is.psrc0] || busy_m[is.psrc1]) begin
      fail_run($sformatf("instruction at pc %h issued before its sources were woken", is.pc));
    end
    issued_cnt++;
    if (is.dest_valid) begin
      pend_preg.push_back(is.pdest);
      pend_due.push_back(cyc + 1 + int'(lfsr_take(2)));
    end else begin
      id_done[(is.pc - PC_BASE) >> 2] = 1'b1;
    end
  endtask

  task automatic check_issues();
    int     idx;
    issue_t got;
    if (alu_issue_o.valid) begin
      got = alu_issue_o;
      idx = -1;
      foreach (exp_alu[k]) begin
        if (exp_alu[k].pc == got.pc) idx = k;
      end
      if (idx < 0) begin
        fail_run($sformatf("ALU issue at pc %h matches no waiting ALU instruction", got.pc));
      end
      check_alu(got, exp_alu[idx]);
      exp_alu.delete(idx);
      note_issue(got);
    end
    if (mem_issue_o.valid) begin
      got = mem_issue_o;
      if (exp_mem.size() == 0) begin
        fail_run("memory issue seen with no memory instruction waiting");
      end
      check_mem(got, exp_mem.pop_front());
      note_issue(got);
    end
  endtask

  task automatic take_accepts();
    rob_alloc_t ra;
    issue_t     is;
    // stage 1 is open when no accepted lane still waits for its allocation
    // decode ready opens on the first edge after reset
    if (cyc > 0) begin
      check_ready(sched_ready_o,
                  (exp_rob.size() == 0) && (fl_m.size() >= `SCHED_DECODE_WIDTH));
    end
    if (withhold && fl_m.size() < 2 && !sched_ready_o) exhausted_seen = 1'b1;
    req_taken = sched_ready_o;
    for (int i = 0; i < `SCHED_DECODE_WIDTH; i++) begin
      if (sched_ready_o && sched_req_i[i].valid) begin
        rename_lane(sched_req_i[i], (sched_req_i[i].pc - PC_BASE) >> 2, ra, is);
        exp_rob.push_back(ra);
        if (op_is_mem(sched_req_i[i].op)) exp_mem.push_back(is);
        else exp_alu.push_back(is);
        acc_cnt++;
      end
    end
  endtask

  task automatic apply_writebacks();
    for (int w = 0; w < `SCHED_WB_WIDTH; w++) begin
      if (wakeup_i[w].valid) begin
        busy_m[wakeup_i[w].preg]            = 1'b0;
        id_done[owner_id[wakeup_i[w].preg]] = 1'b1;
      end
    end
    for (int w = 0; w < `SCHED_WB_WIDTH; w++) begin
      if (free_i[w].valid) fl_m.push_back(free_i[w].preg);
    end
  endtask

  // in-order retirement returns old pdests
  task automatic plan_retire();
    int n;
    free_nxt = '0;
    n        = 0;
    while (!withhold && n < `SCHED_WB_WIDTH && ret_id < acc_cnt && id_done[ret_id]) begin
      if (id_dest[ret_id]) begin
        free_nxt[n].valid = 1'b1;
        free_nxt[n].preg  = id_old[ret_id];
      end
      n++;
      ret_id++;
    end
  endtask

  always @(negedge clk) begin
    if (rst_n) begin
      for (int i = 0; i < `SCHED_DECODE_WIDTH; i++) begin
        if (rob_alloc_o[i].valid) begin
          if (exp_rob.size() == 0) fail_run("ROB allocation seen with nothing accepted");
          check_rob(rob_alloc_o[i], exp_rob.pop_front(), i);
        end
      end
      check_issues();
      take_accepts();
      apply_writebacks();
      plan_retire();
    end
  end

  // ================================================
  // stimulus
  // ================================================
  task automatic gen_request();
    for (int i = 0; i < `SCHED_DECODE_WIDTH; i++) begin
      sched_req_i[i] = '0;
      if (gen_cnt < N_INSTR && lfsr_take(2) != 0) begin
        sched_req_i[i].valid      = 1'b1;
        sched_req_i[i].op         = sched_op_e'(3'(lfsr_take(3) % 6));
        sched_req_i[i].src0       = areg_t'(lfsr_take(5));
        sched_req_i[i].src1       = areg_t'(lfsr_take(5));
        sched_req_i[i].dest       = areg_t'(lfsr_take(5));
        sched_req_i[i].dest_valid = withhold || (lfsr_take(2) != 0);
        sched_req_i[i].pc         = PC_BASE + pc_t'(gen_cnt * 4);
        gen_cnt++;
      end
    end
  endtask

  task automatic drive_wakeups();
    int n, k;
    wakeup_i = '0;
    n        = 0;
    k        = 0;
    while (k < pend_preg.size()) begin
      if (n < `SCHED_WB_WIDTH && pend_due[k] <= cyc) begin
        wakeup_i[n].valid = 1'b1;
        wakeup_i[n].preg  = pend_preg[k];
        pend_preg.delete(k);
        pend_due.delete(k);
        n++;
      end else begin
        k++;
      end
    end
  endtask

  // random stretches of a unit refusing commands
  task automatic stall_unit(inout int hold, output logic rdy);
    if (hold > 0) begin
      hold--;
      rdy = 1'b0;
    end else if (lfsr_take(3) == 0) begin
      hold = 2 + int'(lfsr_take(3));
      rdy  = 1'b0;
    end else begin
      rdy = 1'b1;
    end
  endtask

  task automatic drive_cycle();
    @(posedge clk);
    cyc++;
    if (cyc > CYCLE_LIMIT) fail_run("timeout: instructions did not all issue in time");
    #1;
    drive_wakeups();
    free_i = free_nxt;
    // frees held back until the free list runs dry
    if (withhold && exhausted_seen) begin
      hold_cnt++;
      if (hold_cnt >= 8) begin
        withhold     = 1'b0;
        exhaust_done = 1'b1;
      end
    end else if (!exhaust_done && gen_cnt >= EXHAUST_AT) begin
      withhold = 1'b1;
    end
    if (gen_cnt >= BP_START && gen_cnt < EXHAUST_AT) begin
      rob_ready_i = (lfsr_take(2) != 0);
      stall_unit(alu_hold, alu_ready_i);
      stall_unit(mem_hold, mem_ready_i);
    end else begin
      rob_ready_i = 1'b1;
      alu_ready_i = 1'b1;
      mem_ready_i = 1'b1;
    end
    if (req_taken || !(sched_req_i[0].valid || sched_req_i[1].valid)) gen_request();
  endtask

  initial begin
    rst_n       = 1'b0;
    sched_req_i = '0;
    rob_ready_i = 1'b1;
    free_i      = '0;
    wakeup_i    = '0;
    alu_ready_i = 1'b1;
    mem_ready_i = 1'b1;
    free_nxt    = '0;
    for (int r = 0; r < `SCHED_ARCH_REGS; r++) map_m[r] = preg_t'(r);
    for (int p = `SCHED_ARCH_REGS; p < `SCHED_PHYS_REGS; p++) fl_m.push_back(preg_t'(p));
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;
    while (!(gen_cnt >= N_INSTR && issued_cnt == N_INSTR && exp_rob.size() == 0)) begin
      drive_cycle();
    end
    // extra cycles catch duplicate issues
    repeat (10) drive_cycle();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+verilog
verilog/sched_pkg.sv
verilog/free_list.sv
verilog/rename_table.sv
verilog/issue_queue.sv
verilog/scheduler.sv
tests/scheduler_asserts.sv
tests/scheduler_tb.sv

/* Bender.yml */
package:
  name: scheduler

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/sched_pkg.sv
      - verilog/free_list.sv
      - verilog/rename_table.sv
      - verilog/issue_queue.sv
      - verilog/scheduler.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/scheduler_asserts.sv
      - tests/scheduler_tb.sv
